// File: src/cgra_pkg.sv
package cgra_pkg;

	localparam int ARRAY_DIM  = 2; // Tiles per row and per column.
	localparam int NUM_TRACKS = 4; // Tracks per side.
	localparam int NUM_SIDES  = 4;
	localparam int TRACK_W    = $clog2(NUM_TRACKS);
	localparam int TILE_ID_W  = $clog2(ARRAY_DIM * ARRAY_DIM);

	// Register address on the configuration bus.
	localparam logic REG_SB = 1'b0;
	localparam logic REG_PE = 1'b1;

	// Switch box select codes.
	localparam logic [1:0] SEL_OPP = 2'd0;
	localparam logic [1:0] SEL_CW  = 2'd1;
	localparam logic [1:0] SEL_CCW = 2'd2;
	localparam logic [1:0] SEL_PE  = 2'd3;

	typedef enum logic [1:0] {
		SIDE_N,
		SIDE_E,
		SIDE_S,
		SIDE_W
	} side_e;

	typedef logic [NUM_TRACKS-1:0] track_side_t;
	typedef logic [TRACK_W-1:0] track_idx_t;
	typedef logic [TILE_ID_W-1:0] tile_id_t;
	typedef track_side_t [NUM_SIDES-1:0] side_tracks_t; // Indexed by side_e.

	typedef struct packed {
		track_side_t north;
		track_side_t east;
		track_side_t south;
		track_side_t west;
	} tile_tracks_t;

	// Index 0 is the west tile on north/south edges, the north tile on east/west edges.
	typedef track_side_t [ARRAY_DIM-1:0] edge_tracks_t;

	typedef struct packed {
		edge_tracks_t north;
		edge_tracks_t east;
		edge_tracks_t south;
		edge_tracks_t west;
	} array_io_t;

	typedef struct packed {
		logic        en;      // Write strobe.
		tile_id_t    tile;    // Row * ARRAY_DIM + column.
		logic        reg_sel;
		logic [31:0] data;
	} cfg_bus_t;

	// Select for output side s, track t at bits 2*(4*s+t)+1:2*(4*s+t).
	typedef logic [NUM_SIDES-1:0][NUM_TRACKS-1:0][1:0] sb_cfg_t;

	typedef struct packed {
		side_e      side;
		track_idx_t track;
	} track_sel_t;

	typedef struct packed {
		logic [11:0] rsvd;
		track_sel_t  sel_c;
		track_sel_t  sel_b;
		track_sel_t  sel_a;
		logic [7:0]  lut;
	} pe_cfg_t;

	// One configuration word, read as routing or PE setup by register address.
	typedef union packed {
		sb_cfg_t sb;
		pe_cfg_t pe;
	} cfg_word_u;

	function automatic side_tracks_t to_sides(input tile_tracks_t t);
		side_tracks_t s;
		s[SIDE_N] = t.north;
		s[SIDE_E] = t.east;
		s[SIDE_S] = t.south;
		s[SIDE_W] = t.west;
		return s;
	endfunction

	function automatic tile_tracks_t from_sides(input side_tracks_t s);
		tile_tracks_t t;
		t.north = s[SIDE_N];
		t.east  = s[SIDE_E];
		t.south = s[SIDE_S];
		t.west  = s[SIDE_W];
		return t;
	endfunction

endpackage

// File: src/tile_config.sv
`timescale 1ns/1ps

module tile_config (
	input  logic                clk,
	input  logic                reset,
	input  cgra_pkg::cfg_bus_t  cfg_i,
	input  cgra_pkg::tile_id_t  tile_id_i,
	output cgra_pkg::sb_cfg_t   sb_cfg_o,
	output cgra_pkg::pe_cfg_t   pe_cfg_o
);
	import cgra_pkg::*;

	cfg_word_u sb_word_q;
	cfg_word_u pe_word_q;
	logic      hit;

	assign hit = cfg_i.en && (cfg_i.tile == tile_id_i);

	always_ff @(posedge clk) begin
		if (reset) begin
			sb_word_q <= '0;
			pe_word_q <= '0; // All selects zero so tracks pass straight through.
		end else if (hit) begin
			if (cfg_i.reg_sel == REG_SB) begin
				sb_word_q <= cfg_i.data;
			end
			if (cfg_i.reg_sel == REG_PE) begin
				pe_word_q <= cfg_i.data;
			end
		end
	end

	// Each word is read through its own view of the union.
	assign sb_cfg_o = sb_word_q.sb;
	assign pe_cfg_o = pe_word_q.pe;

endmodule

// File: src/pe_lut.sv
`timescale 1ns/1ps

module pe_lut (
	input  cgra_pkg::tile_tracks_t in_i,
	input  cgra_pkg::pe_cfg_t      pe_cfg_i,
	output logic                   pe_out_o
);
	import cgra_pkg::*;

	side_tracks_t in_side;
	logic         op_a;
	logic         op_b;
	logic         op_c;
	logic [2:0]   lut_idx;

	// One input track chosen by side and track number.
	function automatic logic pick_track(input side_tracks_t sides, input track_sel_t sel);
		track_side_t side_bits;
		side_bits = sides[sel.side];
		return side_bits[sel.track];
	endfunction

	assign in_side = to_sides(in_i);

	assign op_a = pick_track(in_side, pe_cfg_i.sel_a);
	assign op_b = pick_track(in_side, pe_cfg_i.sel_b);
	assign op_c = pick_track(in_side, pe_cfg_i.sel_c);

	// Entry a + 2b + 4c of the table.
	assign lut_idx  = {op_c, op_b, op_a};
	assign pe_out_o = pe_cfg_i.lut[lut_idx];

endmodule

// File: src/switch_box.sv
`timescale 1ns/1ps

module switch_box (
	input  logic                   clk,
	input  logic                   reset,
	input  cgra_pkg::tile_tracks_t in_i,
	input  logic                   pe_out_i,
	input  cgra_pkg::sb_cfg_t      sb_cfg_i,
	output cgra_pkg::tile_tracks_t out_o
);
	import cgra_pkg::*;

	side_tracks_t in_side;
	side_tracks_t route_d;
	side_tracks_t route_q;

	// Sides seen from output side s, with north, east, south, west as 0 to 3.
	function automatic int opp_of(input int s);
		return (s + 2) % NUM_SIDES;
	endfunction

	function automatic int cw_of(input int s);
		return (s + 1) % NUM_SIDES;
	endfunction

	function automatic int ccw_of(input int s);
		return (s + NUM_SIDES - 1) % NUM_SIDES;
	endfunction

	assign in_side = to_sides(in_i);

	always_comb begin
		route_d = '0;
		for (int s = 0; s < NUM_SIDES; s++) begin
			for (int t = 0; t < NUM_TRACKS; t++) begin
				case (sb_cfg_i[s][t])
					SEL_OPP: route_d[s][t] = in_side[opp_of(s)][t]; // Straight through.
					SEL_CW:  route_d[s][t] = in_side[cw_of(s)][t];
					SEL_CCW: route_d[s][t] = in_side[ccw_of(s)][t];
					SEL_PE:  route_d[s][t] = pe_out_i;
					default: route_d[s][t] = 1'b0;
				endcase
			end
		end
	end

	// One register per output track, so each hop costs one cycle
	// and no combinational loop forms between tiles.
	always_ff @(posedge clk) begin
		if (reset) begin
			route_q <= '0;
		end else begin
			route_q <= route_d;
		end
	end

	assign out_o = from_sides(route_q);

endmodule

// File: src/cgra_tile.sv
`timescale 1ns/1ps

module cgra_tile (
	input  logic                   clk,
	input  logic                   reset,
	input  cgra_pkg::cfg_bus_t     cfg_i,
	input  cgra_pkg::tile_id_t     tile_id_i,
	input  cgra_pkg::tile_tracks_t in_i,
	output cgra_pkg::tile_tracks_t out_o
);
	import cgra_pkg::*;

	sb_cfg_t sb_cfg;
	pe_cfg_t pe_cfg;
	logic    pe_out;

	tile_config u_tile_config (
		.clk       (clk),
		.reset     (reset),
		.cfg_i     (cfg_i),
		.tile_id_i (tile_id_i),
		.sb_cfg_o  (sb_cfg),
		.pe_cfg_o  (pe_cfg)
	);

	// PE sees the raw tile inputs; its result is registered in the switch box.
	pe_lut u_pe_lut (
		.in_i     (in_i),
		.pe_cfg_i (pe_cfg),
		.pe_out_o (pe_out)
	);

	switch_box u_switch_box (
		.clk      (clk),
		.reset    (reset),
		.in_i     (in_i),
		.pe_out_i (pe_out),
		.sb_cfg_i (sb_cfg),
		.out_o    (out_o)
	);

endmodule

// File: src/cgra_array.sv
`timescale 1ns/1ps

module cgra_array (
	input  logic                clk,
	input  logic                reset,
	input  cgra_pkg::cfg_bus_t  cfg_i,
	input  cgra_pkg::array_io_t io_in_i,
	output cgra_pkg::array_io_t io_out_o
);
	import cgra_pkg::*;

	tile_tracks_t tile_in  [ARRAY_DIM][ARRAY_DIM]; // [row][column].
	tile_tracks_t tile_out [ARRAY_DIM][ARRAY_DIM];

	for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
		for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
			cgra_tile u_cgra_tile (
				.clk       (clk),
				.reset     (reset),
				.cfg_i     (cfg_i), // Same bus for every tile.
				.tile_id_i (tile_id_t'(r * ARRAY_DIM + c)),
				.in_i      (tile_in[r][c]),
				.out_o     (tile_out[r][c])
			);
		end
	end

	// A tile's input on one side is the facing output of its neighbour,
	// or the perimeter input at the array edge.
	always_comb begin
		for (int r = 0; r < ARRAY_DIM; r++) begin
			for (int c = 0; c < ARRAY_DIM; c++) begin
				if (r == 0) begin
					tile_in[r][c].north = io_in_i.north[c];
				end else begin
					tile_in[r][c].north = tile_out[r-1][c].south;
				end
				if (r == ARRAY_DIM - 1) begin
					tile_in[r][c].south = io_in_i.south[c];
				end else begin
					tile_in[r][c].south = tile_out[r+1][c].north;
				end
				if (c == 0) begin
					tile_in[r][c].west = io_in_i.west[r];
				end else begin
					tile_in[r][c].west = tile_out[r][c-1].east;
				end
				if (c == ARRAY_DIM - 1) begin
					tile_in[r][c].east = io_in_i.east[r];
				end else begin
					tile_in[r][c].east = tile_out[r][c+1].west;
				end
			end
		end
	end

	// Perimeter outputs come from the edge tiles.
	always_comb begin
		for (int i = 0; i < ARRAY_DIM; i++) begin
			io_out_o.north[i] = tile_out[0][i].north;
			io_out_o.south[i] = tile_out[ARRAY_DIM-1][i].south;
			io_out_o.west[i]  = tile_out[i][0].west;
			io_out_o.east[i]  = tile_out[i][ARRAY_DIM-1].east;
		end
	end

endmodule

// File: tb/cgra_array_asserts.sv
`timescale 1ns/1ps

module cgra_array_asserts (
	input logic               clk,
	input logic               reset,
	input cgra_pkg::cfg_bus_t cfg_i,
	input cgra_pkg::tile_id_t tile_id_i,
	input cgra_pkg::sb_cfg_t  sb_cfg_i,
	input cgra_pkg::pe_cfg_t  pe_cfg_i
);
	import cgra_pkg::*;

	int   error_count = 0; // Count of failed assertions.
	logic hit_sb;
	logic hit_pe;

	assign hit_sb = cfg_i.en && (cfg_i.tile == tile_id_i) && (cfg_i.reg_sel == REG_SB);
	assign hit_pe = cfg_i.en && (cfg_i.tile == tile_id_i) && (cfg_i.reg_sel == REG_PE);

	reset_clears: assert property (@(posedge clk) reset |=> (sb_cfg_i == '0 && pe_cfg_i == '0))
		else begin
			$error("Configuration words not zero after reset.");
			error_count++;
		end

	// A word may only move after a write to it, or when reset clears it.
	sb_change_needs_write: assert property (@(posedge clk) disable iff (reset)
		!$stable(sb_cfg_i) |-> ($past(hit_sb) || $past(reset)))
		else begin
			$error("Routing word changed without a matching write.");
			error_count++;
		end

	pe_change_needs_write: assert property (@(posedge clk) disable iff (reset)
		!$stable(pe_cfg_i) |-> ($past(hit_pe) || $past(reset)))
		else begin
			$error("PE word changed without a matching write.");
			error_count++;
		end

	sb_write_visible: assert property (@(posedge clk) disable iff (reset)
		hit_sb |=> (sb_cfg_i == $past(cfg_i.data)))
		else begin
			$error("Routing write not visible on the next cycle.");
			error_count++;
		end

	pe_write_visible: assert property (@(posedge clk) disable iff (reset)
		hit_pe |=> (pe_cfg_i == $past(cfg_i.data)))
		else begin
			$error("PE write not visible on the next cycle.");
			error_count++;
		end

endmodule

bind tile_config cgra_array_asserts u_cgra_array_asserts (
	.clk       (clk),
	.reset     (reset),
	.cfg_i     (cfg_i),
	.tile_id_i (tile_id_i),
	.sb_cfg_i  (sb_cfg_o),
	.pe_cfg_i  (pe_cfg_o)
);

// File: tb/cgra_array_tb.sv
`timescale 1ns/1ps

module cgra_array_tb;
	import cgra_pkg::*;

	localparam int NUM_TILES       = ARRAY_DIM * ARRAY_DIM;
	localparam int STRAIGHT_CYCLES = 24;
	localparam int ROUTE_ROUNDS    = 3;
	localparam int ROUTE_CYCLES    = 32;
	localparam int PE_ROUNDS       = 3;
	localparam int PE_CYCLES       = 32;
	localparam int ISO_CYCLES      = 60;
	localparam int RECFG_CYCLES    = 60;
	localparam int TOTAL_CYCLES    = 3 + 2 * STRAIGHT_CYCLES + ROUTE_ROUNDS * (4 + ROUTE_CYCLES)
		+ PE_ROUNDS * (8 + PE_CYCLES) + ISO_CYCLES + RECFG_CYCLES + 2 + 7;
	localparam int CYCLE_LIMIT     = TOTAL_CYCLES + 50;

	logic        clk = 1'b0;
	logic        reset;
	cfg_bus_t    cfg;
	array_io_t   io_in;
	array_io_t   io_out;
	array_io_t   in_d1; // Perimeter input of the cycle before.
	logic [31:0] lfsr_state;
	string       test_name;
	int          cycle_count = 0;

	// Model state with sides indexed north 0, east 1, south 2, west 3.
	logic [3:0]  mout [NUM_TILES][NUM_SIDES];
	logic [3:0]  m_in [NUM_TILES][NUM_SIDES];
	logic [31:0] m_sb [NUM_TILES];
	logic [31:0] m_pe [NUM_TILES];

	cgra_array u_cgra_array (
		.clk      (clk),
		.reset    (reset),
		.cfg_i    (cfg),
		.io_in_i  (io_in),
		.io_out_o (io_out)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("Some tests failed");
			$fatal(1, "Run stopped by the cycle limit.");
		end
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Output mismatch in %s.", name);
		end
	endtask

	// LUT index is a + 2b + 4c; each select is side in [3:2], track in [1:0].
	function automatic logic pe_result(input int k);
		logic [3:0] ca;
		logic [3:0] cb;
		logic [3:0] cc;
		logic [2:0] idx;
		ca = m_pe[k][11:8];
		cb = m_pe[k][15:12];
		cc = m_pe[k][19:16];
		idx = {m_in[k][cc[3:2]][cc[1:0]], m_in[k][cb[3:2]][cb[1:0]], m_in[k][ca[3:2]][ca[1:0]]};
		return m_pe[k][idx];
	endfunction

	function automatic logic route_bit(input int k, input int s, input int t);
		logic [1:0] sel;
		logic       b;
		sel = m_sb[k][2 * (4 * s + t) +: 2];
		case (sel)
			2'd0: b = m_in[k][(s + 2) % 4][t]; // Opposite side.
			2'd1: b = m_in[k][(s + 1) % 4][t]; // Clockwise.
			2'd2: b = m_in[k][(s + 3) % 4][t];
			default: b = pe_result(k);
		endcase
		return b;
	endfunction

	task automatic model_step();
		logic [3:0] nxt [NUM_TILES][NUM_SIDES];
		int         k;
		if (reset) begin
			for (int i = 0; i < NUM_TILES; i++) begin
				m_sb[i] = '0;
				m_pe[i] = '0;
				for (int s = 0; s < NUM_SIDES; s++) begin
					mout[i][s] = '0;
				end
			end
		end else begin
			for (int r = 0; r < ARRAY_DIM; r++) begin
				for (int c = 0; c < ARRAY_DIM; c++) begin
					k = r * ARRAY_DIM + c;
					m_in[k][0] = (r == 0) ? io_in.north[c] : mout[k - ARRAY_DIM][2];
					m_in[k][2] = (r == ARRAY_DIM - 1) ? io_in.south[c] : mout[k + ARRAY_DIM][0];
					m_in[k][3] = (c == 0) ? io_in.west[r] : mout[k - 1][1];
					m_in[k][1] = (c == ARRAY_DIM - 1) ? io_in.east[r] : mout[k + 1][3];
				end
			end
			for (int i = 0; i < NUM_TILES; i++) begin
				for (int s = 0; s < NUM_SIDES; s++) begin
					for (int t = 0; t < NUM_TRACKS; t++) begin
						nxt[i][s][t] = route_bit(i, s, t);
					end
				end
			end
			mout = nxt;
			// Config loads after the outputs, so a write counts from the next edge.
			if (cfg.en) begin
				if (cfg.reg_sel) begin
					m_pe[cfg.tile] = cfg.data;
				end else begin
					m_sb[cfg.tile] = cfg.data;
				end
			end
		end
	endtask

	function automatic array_io_t expected_io();
		array_io_t e;
		for (int i = 0; i < ARRAY_DIM; i++) begin
			e.north[i] = mout[i][0];
			e.south[i] = mout[(ARRAY_DIM - 1) * ARRAY_DIM + i][2];
			e.west[i]  = mout[i * ARRAY_DIM][3];
			e.east[i]  = mout[i * ARRAY_DIM + ARRAY_DIM - 1][1];
		end
		return e;
	endfunction

	function automatic array_io_t straight_of(input array_io_t v);
		array_io_t e;
		e.north = v.south;
		e.south = v.north;
		e.east  = v.west;
		e.west  = v.east;
		return e;
	endfunction

	// Failed assertions summed over the four tiles.
	function automatic int assert_failures();
		return u_cgra_array.g_row[0].g_col[0].u_cgra_tile.u_tile_config
			.u_cgra_array_asserts.error_count
			+ u_cgra_array.g_row[0].g_col[1].u_cgra_tile.u_tile_config
			.u_cgra_array_asserts.error_count
			+ u_cgra_array.g_row[1].g_col[0].u_cgra_tile.u_tile_config
			.u_cgra_array_asserts.error_count
			+ u_cgra_array.g_row[1].g_col[1].u_cgra_tile.u_tile_config
			.u_cgra_array_asserts.error_count;
	endfunction

	// Steps the model on each clock edge and compares before the next drive.
	task automatic next_cycle();
		@(posedge clk);
		model_step();
		#1;
		check_value(test_name, expected_io(), io_out);
		if (assert_failures() != 0) begin
			$display("An assertion on the configuration registers failed in %s.", test_name);
			$display("Some tests failed");
			$fatal(1, "Assertion failure seen.");
		end
		#1;
	endtask

	task automatic drive_io(input array_io_t v);
		in_d1 = io_in;
		io_in = v;
	endtask

	task automatic idle_cfg();
		cfg.en      = 1'b0;
		cfg.tile    = tile_id_t'(rand_bits(2)); // Ignored while en is low.
		cfg.reg_sel = 1'(rand_bits(1));
		cfg.data    = rand_bits(32);
	endtask

	function automatic logic [31:0] random_route(input logic allow_pe);
		logic [31:0] w;
		logic [1:0]  sel;
		w = '0;
		for (int i = 0; i < NUM_SIDES * NUM_TRACKS; i++) begin
			if (allow_pe) begin
				sel = 2'(rand_bits(2));
			end else begin
				sel = 2'(rand_bits(4) % 3);
			end
			w[2 * i +: 2] = sel;
		end
		return w;
	endfunction

	task automatic write_word(input int tile, input logic reg_sel, input logic [31:0] data);
		cfg.en      = 1'b1;
		cfg.tile    = tile_id_t'(tile);
		cfg.reg_sel = reg_sel;
		cfg.data    = data;
		drive_io(array_io_t'(rand_bits(32)));
		next_cycle();
		idle_cfg();
	endtask

	task automatic traffic(input int n);
		repeat (n) begin
			idle_cfg();
			drive_io(array_io_t'(rand_bits(32)));
			next_cycle();
		end
	endtask

	task automatic straight_phase();
		for (int i = 0; i < STRAIGHT_CYCLES; i++) begin
			idle_cfg();
			drive_io(array_io_t'(rand_bits(32)));
			next_cycle();
			if (i >= 2) begin
				check_value("straight two-cycle delay", straight_of(in_d1), io_out);
			end
		end
	endtask

	task automatic routing_round();
		for (int k = 0; k < NUM_TILES; k++) begin
			write_word(k, REG_SB, random_route(1'b0));
		end
		traffic(ROUTE_CYCLES);
	endtask

	task automatic pe_round();
		for (int k = 0; k < NUM_TILES; k++) begin
			write_word(k, REG_PE, rand_bits(32));
			write_word(k, REG_SB, random_route(1'b1));
		end
		traffic(PE_CYCLES);
	endtask

	// Random writes to any tile and word while traffic runs.
	task automatic mixed_writes(input int n, input int en_bits);
		repeat (n) begin
			cfg.en      = (rand_bits(en_bits) == 0);
			cfg.tile    = tile_id_t'(rand_bits(2));
			cfg.reg_sel = 1'(rand_bits(1));
			cfg.data    = rand_bits(32);
			drive_io(array_io_t'(rand_bits(32)));
			next_cycle();
		end
		idle_cfg();
	endtask

	// PE set to constant one, then tile 0 switched to PE on every track.
	task automatic write_timing();
		cfg = '0;
		drive_io('0);
		repeat (4) next_cycle();
		cfg = '{en: 1'b1, tile: 2'd0, reg_sel: REG_PE, data: 32'h0000_00ff};
		next_cycle();
		cfg = '{en: 1'b1, tile: 2'd0, reg_sel: REG_SB, data: 32'hffff_ffff};
		next_cycle();
		check_value("write timing first edge", 32'h0, {28'h0, io_out.north[0]});
		cfg = '0;
		next_cycle();
		check_value("write timing second edge", 32'hf, {28'h0, io_out.north[0]});
	endtask

	initial begin
		lfsr_state = 32'hcf2490d7;
		reset      = 1'b1;
		cfg        = '0;
		io_in      = '0;
		in_d1      = '0;
		test_name  = "reset";
		repeat (3) next_cycle();
		reset = 1'b0;

		test_name = "straight";
		straight_phase();
		test_name = "routing";
		repeat (ROUTE_ROUNDS) routing_round();
		test_name = "pe";
		repeat (PE_ROUNDS) pe_round();
		test_name = "isolation";
		mixed_writes(ISO_CYCLES, 2);
		test_name = "reconfiguration";
		mixed_writes(RECFG_CYCLES, 1);

		test_name = "mid-run reset";
		reset = 1'b1;
		repeat (2) begin
			cfg = '{en: 1'b1, tile: tile_id_t'(rand_bits(2)), reg_sel: 1'(rand_bits(1)),
				data: rand_bits(32)};
			drive_io(array_io_t'(rand_bits(32)));
			next_cycle();
		end
		reset = 1'b0;
		straight_phase();

		test_name = "write timing";
		write_timing();

		$display("All tests passed");
		$finish;
	end

endmodule

// File: cgra_array.f
src/cgra_pkg.sv
src/tile_config.sv
src/pe_lut.sv
src/switch_box.sv
src/cgra_tile.sv
src/cgra_array.sv
tb/cgra_array_asserts.sv
tb/cgra_array_tb.sv
